// File: verif/video_link_patterns.txt
# one frame per line: width (even pixels), line count, blanking (pclk cycles, vs high)
# blanking stays at 10 or more so both FIFO clears settle before pixels arrive
8 3 12
16 2 10
2 4 15
64 2 20
4 6 11
32 3 10
128 1 25
10 5 14
6 3 10
256 2 30
12 4 16
2 1 10
48 2 18
20 3 12
512 1 40
14 2 10
40 4 22
8 8 13
100 2 17
18 3 10
24 1 11
36 2 19
4 2 10
80 3 24
22 2 12
16 5 10

// File: list.f
design/video_link_pkg.sv
design/vs_frame_sync.sv
design/pixel_async_fifo.sv
design/video_packet_send.sv
design/video_link_tx.sv
verif/video_link_clk_gen.sv
verif/video_link_assert.sv
verif/video_link_tb.sv

// File: Bender.yml
package:
  name: video_link_tx

sources:
  - files:
      - design/video_link_pkg.sv
      - design/vs_frame_sync.sv
      - design/pixel_async_fifo.sv
      - design/video_packet_send.sv
      - design/video_link_tx.sv
  - target: simulation
    files:
      - verif/video_link_clk_gen.sv
      - verif/video_link_assert.sv
      - verif/video_link_tb.sv

// File: verif/video_link_tb.sv
`timescale 1ns/10ps

module video_link_tb
    import video_link_pkg::*;
();

    logic        tx_clk;
    logic        pclk;
    logic        rst;
    logic        vs;
    logic        de;
    pixel_t      vin_data;
    line_len_t   vin_width;
    link_word_t  gt_tx_data;
    link_ctrl_t  gt_tx_ctrl;

    int          pat_width [64];                              // room for 64 frames
    int          pat_lines [64];
    int          pat_blank [64];
    int          num_patterns;
    pixel_t      pixel_q [$];                                 // pixels sent, not yet seen
    int          value_errors;
    int          other_errors;
    int unsigned cycle_cnt;
    int unsigned cycle_limit = 32'hffff_ffff;
    int          frames_sent;
    int          lines_planned;
    int          line_ends_total;

    logic        link_up;                                     // framer has emitted a word
    logic        expect_sync1;
    logic        in_line;
    logic        next_idle1;
    link_word_t  last_word;
    int          words_left;
    int          frames_seen;
    int          lines_in_frame;

    video_link_clk_gen u_clk_gen (.tx_clk(tx_clk), .pclk(pclk));

    video_link_tx video_link_tx_i (
        .tx_clk     (tx_clk),
        .rst        (rst),
        .pclk       (pclk),
        .vs         (vs),
        .de         (de),
        .vin_data   (vin_data),
        .vin_width  (vin_width),
        .gt_tx_data (gt_tx_data),
        .gt_tx_ctrl (gt_tx_ctrl)
    );

    task automatic value_error(input string test, input logic [31:0] exp, input logic [31:0] act);
        value_errors++;
        $display("ERROR %s: expected %h, actual %h (%0t)", test, exp, act, $time);
    endtask

    task automatic plain_error(input string what);
        other_errors++;
        $display("Check failed at %0t: %s", $time, what);
    endtask

    task automatic read_patterns();
        int    fd;
        int    w;
        int    l;
        int    b;
        string text;
        num_patterns = 0;
        fd = $fopen("verif/video_link_patterns.txt", "r");
        if (fd == 0)
            plain_error("cannot open verif/video_link_patterns.txt");
        while (fd != 0 && !$feof(fd) && num_patterns < 64)
        begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() > 0 && text[0] != "#" && $sscanf(text, "%d %d %d", w, l, b) == 3)
            begin
                pat_width[num_patterns] = w;
                pat_lines[num_patterns] = l;
                pat_blank[num_patterns] = b;
                num_patterns++;
            end
        end
        if (fd != 0)
            $fclose(fd);
    endtask

    task automatic check_line_count();
        if (frames_seen > 0 && lines_in_frame != pat_lines[frames_seen - 1])
            value_error("line_count", pat_lines[frames_seen - 1], lines_in_frame);
    endtask

    task automatic send_frame(input int f);
        int     ln;
        int     p;
        pixel_t px;
        @(posedge pclk);
        vs        <= 1'b1;
        vin_width <= line_len_t'(pat_width[f]);
        frames_sent++;
        repeat (pat_blank[f]) @(posedge pclk);                // lets both FIFO clears settle
        vs <= 1'b0;
        for (ln = 0; ln < pat_lines[f]; ln++)
        begin
            for (p = 0; p < pat_width[f]; p++)
            begin
                px = pixel_t'($urandom);
                de       <= 1'b1;
                vin_data <= px;
                pixel_q.push_back(px);
                @(posedge pclk);
            end
            de <= 1'b0;
            repeat (4) @(posedge pclk);                       // short gap between lines
        end
        lines_planned += pat_lines[f];
        while (line_ends_total < lines_planned)               // frame drained on the link
            @(posedge pclk);
        repeat (4) @(posedge pclk);
    endtask

    task automatic parse_word(input link_word_t word, input link_ctrl_t ctrl);
        pixel_t     lo;
        pixel_t     hi;
        link_ctrl_t exp_ctrl;
        link_word_t exp_idle;
        exp_ctrl = (in_line && words_left > 0) ? CTRL_DATA : CTRL_K0;
        exp_idle = next_idle1 ? IDLE1_WORD : IDLE0_WORD;
        if (ctrl !== exp_ctrl)
            value_error("ctrl_mask", exp_ctrl, ctrl);
        if (expect_sync1)
        begin
            expect_sync1 = 1'b0;
            next_idle1   = 1'b0;
            if (word !== FRAME_SYNC1_WORD)
                value_error("frame_sync", FRAME_SYNC1_WORD, word);
        end
        else if (in_line && words_left > 0)
        begin
            words_left--;
            if (pixel_q.size() < 2)
                plain_error("data word arrived with fewer than two pixels pending");
            else
            begin
                lo = pixel_q.pop_front();                     // earlier pixel, low half
                hi = pixel_q.pop_front();
                if (word !== {hi, lo})
                    value_error("pixel_data", {hi, lo}, word);
            end
        end
        else if (in_line)
        begin
            in_line    = 1'b0;
            next_idle1 = 1'b0;
            line_ends_total++;
            if (word !== LINE_END_WORD)
                value_error("line_end", LINE_END_WORD, word);
        end
        else if (word === FRAME_SYNC0_WORD)
        begin
            check_line_count();
            if (frames_seen >= frames_sent)
                plain_error("frame sync without a rising edge of vs");
            if (pixel_q.size() != 0)
                plain_error("pixels of the previous frame still pending at frame sync");
            frames_seen++;
            lines_in_frame = 0;
            expect_sync1   = 1'b1;
        end
        else if (word === LINE_START_WORD && frames_seen > 0)
        begin
            if (last_word !== IDLE1_WORD)
                value_error("line_start_order", IDLE1_WORD, last_word);
            lines_in_frame++;
            in_line    = 1'b1;
            words_left = pat_width[frames_seen - 1] / 2;
        end
        else
        begin
            if (word !== exp_idle)
                value_error("idle", exp_idle, word);
            next_idle1 = !next_idle1;
        end
        last_word = word;
    endtask

    always @(negedge tx_clk)                                  // outputs settled mid-cycle
    begin
        if (rst)
        begin
            if (gt_tx_ctrl !== 4'b0000)
                value_error("reset_ctrl", 32'h0, gt_tx_ctrl);
        end
        else if (link_up || gt_tx_data !== '0 || gt_tx_ctrl !== '0)
        begin
            link_up = 1'b1;
            parse_word(gt_tx_data, gt_tx_ctrl);
        end
    end

    always @(posedge tx_clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("Timeout after %0d tx_clk cycles, %0d wrong values, %0d other failures",
                     cycle_cnt, value_errors, other_errors);
            $display("Something failed");
            $finish;
        end
    end

    initial
    begin
        int f;
        rst       = 1'b1;
        vs        = 1'b0;
        de        = 1'b0;
        vin_data  = '0;
        vin_width = 16'd8;                                    // nonzero even width while idle
        value_errors = 0;
        other_errors = 0;
        cycle_cnt = 0;
        frames_sent = 0;
        lines_planned = 0;
        line_ends_total = 0;
        link_up = 1'b0;
        expect_sync1 = 1'b0;
        in_line = 1'b0;
        next_idle1 = 1'b0;
        last_word = '0;
        words_left = 0;
        frames_seen = 0;
        lines_in_frame = 0;
        void'($urandom(4840));                                // seed once
        read_patterns();
        cycle_limit = 200;
        for (f = 0; f < num_patterns; f++)
            cycle_limit += 2 * (((pat_blank[f] + pat_lines[f] * (pat_width[f] + 4)) * 5) / 4
                                + pat_lines[f] * (pat_width[f] / 2 + 8) + 40);
        repeat (5) @(posedge tx_clk);
        rst <= 1'b0;
        repeat (24) @(posedge tx_clk);                        // idle stream before the first vs
        for (f = 0; f < num_patterns; f++)
            send_frame(f);
        repeat (24) @(posedge tx_clk);
        check_line_count();
        if (num_patterns == 0)
            plain_error("no frame patterns were read");
        if (frames_seen != num_patterns)
            value_error("frame_count", num_patterns, frames_seen);
        if (pixel_q.size() != 0)
            plain_error("pixels were sent that never appeared on the link");
        $display("Errors: %0d wrong values, %0d other failures, %0d assertion failures",
                 value_errors, other_errors,
                 video_link_tx_i.u_video_packet_send.u_video_link_assert.fail_cnt);
        if (value_errors + other_errors +
            video_link_tx_i.u_video_packet_send.u_video_link_assert.fail_cnt == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: verif/video_link_assert.sv
`timescale 1ns/10ps

module video_link_assert
    import video_link_pkg::*;
(
    input logic          tx_clk,
    input logic          rst,
    input framer_state_e state,
    input logic          rd_en,
    input link_word_t    rd_data,
    input link_word_t    gt_tx_data,
    input link_ctrl_t    gt_tx_ctrl
);

    int fail_cnt = 0;                                         // assertion failures so far

    ctrl_k0_outside_data: assert property (@(posedge tx_clk) disable iff (rst)
        (state != SEND_LINE_DATA) |=> (gt_tx_ctrl == CTRL_K0))
    else
    begin
        fail_cnt++;
        $error("gt_tx_ctrl is not CTRL_K0 after a non-data state");
    end

    // every read word leaves the link as data in the next cycle
    rd_en_in_data_only: assert property (@(posedge tx_clk) disable iff (rst)
        rd_en |=> (gt_tx_ctrl == CTRL_DATA && gt_tx_data == $past(rd_data)))
    else
    begin
        fail_cnt++;
        $error("rd_en high without the head word going out as data");
    end

    // sync pair is never split
    sync1_after_sync0: assert property (@(posedge tx_clk) disable iff (rst)
        (gt_tx_data == FRAME_SYNC0_WORD) |=> (gt_tx_data == FRAME_SYNC1_WORD))
    else
    begin
        fail_cnt++;
        $error("FRAME_SYNC0 not followed by FRAME_SYNC1");
    end

endmodule

bind video_packet_send video_link_assert u_video_link_assert (
    .tx_clk      (tx_clk),
    .rst         (rst),
    .state       (state),
    .rd_en       (rd_en),
    .rd_data     (rd_data),
    .gt_tx_data  (gt_tx_data),
    .gt_tx_ctrl  (gt_tx_ctrl)
);

// File: verif/video_link_clk_gen.sv
`timescale 1ns/10ps

module video_link_clk_gen (
    output logic tx_clk,
    output logic pclk
);

    initial
    begin
        tx_clk = 1'b0;
        pclk   = 1'b0;
    end

    always #20 tx_clk = ~tx_clk;                              // 40 ns link clock
    always #25 pclk = ~pclk;                                  // 50 ns camera clock, rising edges never meet

endmodule

// File: design/video_link_tx.sv
`timescale 1ns/10ps

module video_link_tx
    import video_link_pkg::*;
(
    input  logic       tx_clk,
    input  logic       rst,
    input  logic       pclk,
    input  logic       vs,
    input  logic       de,
    input  pixel_t     vin_data,
    input  line_len_t  vin_width,
    output link_word_t gt_tx_data,
    output link_ctrl_t gt_tx_ctrl
);

    logic        frame_start_pclk;                            // clears write side
    logic        frame_start_tx;                              // clears read side, restarts framer
    fifo_level_t fifo_level;
    link_word_t  rd_data;
    logic        rd_en;

    vs_frame_sync u_vs_frame_sync (
        .tx_clk           (tx_clk),
        .pclk             (pclk),
        .rst              (rst),
        .vs               (vs),
        .frame_start_pclk (frame_start_pclk),
        .frame_start_tx   (frame_start_tx)
    );

    pixel_async_fifo u_pixel_async_fifo (
        .pclk       (pclk),
        .wr_clear   (frame_start_pclk),
        .wr_en      (de),
        .wr_data    (vin_data),
        .tx_clk     (tx_clk),
        .rd_clear   (frame_start_tx),
        .rd_en      (rd_en),
        .rst        (rst),
        .rd_data    (rd_data),
        .fifo_level (fifo_level)
    );

    video_packet_send u_video_packet_send (
        .tx_clk      (tx_clk),
        .rst         (rst),
        .frame_start (frame_start_tx),
        .vin_width   (vin_width),
        .fifo_level  (fifo_level),
        .rd_data     (rd_data),
        .rd_en       (rd_en),
        .gt_tx_data  (gt_tx_data),
        .gt_tx_ctrl  (gt_tx_ctrl)
    );

endmodule

// File: design/video_packet_send.sv
`timescale 1ns/10ps

module video_packet_send
    import video_link_pkg::*;
(
    input  logic        tx_clk,
    input  logic        rst,
    input  logic        frame_start,
    input  line_len_t   vin_width,
    input  fifo_level_t fifo_level,
    input  link_word_t  rd_data,
    output logic        rd_en,
    output link_word_t  gt_tx_data,
    output link_ctrl_t  gt_tx_ctrl
);

    framer_state_e state;
    line_len_t     word_cnt;                                  // data words sent this line
    line_len_t     line_words;                                // pixel pairs per line
    logic          line_ready;

    assign line_words = {1'b0, vin_width[15:1]};
    assign line_ready = line_len_t'(fifo_level) >= vin_width; // a whole line is buffered

    // head word is taken in the same cycle it is registered out
    assign rd_en = (state == SEND_LINE_DATA);

    always_ff @(posedge tx_clk or posedge rst)
    begin
        if (rst)
        begin
            state      <= SEND_IDLE0;
            word_cnt   <= '0;
            gt_tx_data <= '0;
            gt_tx_ctrl <= '0;
        end
        else
        begin
            case (state)
                SEND_FRAME_SYNC0:
                begin
                    gt_tx_data <= FRAME_SYNC0_WORD;
                    gt_tx_ctrl <= CTRL_K0;
                    state      <= SEND_FRAME_SYNC1;
                end
                SEND_FRAME_SYNC1:
                begin
                    gt_tx_data <= FRAME_SYNC1_WORD;
                    gt_tx_ctrl <= CTRL_K0;
                    state      <= SEND_IDLE0;
                end
                SEND_IDLE0:
                begin
                    gt_tx_data <= IDLE0_WORD;
                    gt_tx_ctrl <= CTRL_K0;
                    state      <= SEND_IDLE1;
                end
                SEND_IDLE1:
                begin
                    gt_tx_data <= IDLE1_WORD;
                    gt_tx_ctrl <= CTRL_K0;
                    if (line_ready)
                    begin
                        state <= SEND_LINE_START;
                    end
                    else
                    begin
                        state <= SEND_IDLE0;                  // keep idling in pairs
                    end
                end
                SEND_LINE_START:
                begin
                    gt_tx_data <= LINE_START_WORD;
                    gt_tx_ctrl <= CTRL_K0;
                    word_cnt   <= '0;
                    state      <= SEND_LINE_DATA;
                end
                SEND_LINE_DATA:
                begin
                    gt_tx_data <= rd_data;
                    gt_tx_ctrl <= CTRL_DATA;
                    word_cnt   <= word_cnt + 1'b1;
                    if (word_cnt == line_words - 1'b1)
                    begin
                        state <= SEND_LINE_END;               // last pair of the line
                    end
                end
                SEND_LINE_END:
                begin
                    gt_tx_data <= LINE_END_WORD;
                    gt_tx_ctrl <= CTRL_K0;
                    state      <= SEND_IDLE0;
                end
                default:
                begin
                    state <= SEND_IDLE0;
                end
            endcase
            // current state still sends its word, only the next state changes
            if (frame_start)
            begin
                state    <= SEND_FRAME_SYNC0;                 // wins over any state
                word_cnt <= '0;
            end
        end
    end

endmodule

// File: design/pixel_async_fifo.sv
`timescale 1ns/10ps

module pixel_async_fifo
    import video_link_pkg::*;
(
    input  logic        pclk,
    input  logic        wr_clear,
    input  logic        wr_en,
    input  pixel_t      wr_data,
    input  logic        tx_clk,
    input  logic        rd_clear,
    input  logic        rd_en,
    input  logic        rst,
    output link_word_t  rd_data,
    output fifo_level_t fifo_level
);

    localparam int PAIR_PTR_W = PIXEL_ADDR_W;                 // pair pointer incl. wrap bit

    function automatic logic [PIXEL_ADDR_W:0] gray_to_bin(input logic [PIXEL_ADDR_W:0] gray);
        logic [PIXEL_ADDR_W:0] bin;
        int                    i;
        bin[PIXEL_ADDR_W] = gray[PIXEL_ADDR_W];
        for (i = PIXEL_ADDR_W - 1; i >= 0; i--)
        begin
            bin[i] = bin[i + 1] ^ gray[i];
        end
        return bin;
    endfunction

    pixel_t mem [PIXEL_FIFO_DEPTH / 2][2];                    // [pair][0] is the earlier pixel

    logic [PIXEL_ADDR_W:0] wr_ptr;                            // pixel pointer, msb wraps
    logic [PIXEL_ADDR_W:0] wr_ptr_next;
    logic [PIXEL_ADDR_W:0] wr_gray;
    logic [PAIR_PTR_W-1:0] rd_gray_s0;                        // read pointer into pclk
    logic [PAIR_PTR_W-1:0] rd_gray_s1;
    logic [PIXEL_ADDR_W:0] rd_pair_wr;
    logic [PIXEL_ADDR_W:0] wr_used;
    logic                  fifo_full;
    logic                  wr_accept;

    logic [PAIR_PTR_W-1:0]   rd_ptr;                          // counts pixel pairs
    logic [PAIR_PTR_W-1:0]   rd_ptr_next;
    logic [PAIR_PTR_W-1:0]   rd_gray;
    logic [PIXEL_ADDR_W:0]   wr_gray_s0;                      // write pointer into tx_clk
    logic [PIXEL_ADDR_W:0]   wr_gray_s1;
    logic [PIXEL_ADDR_W:0]   wr_ptr_rd;
    logic [PAIR_PTR_W-2:0]   rd_addr;

    // write side, pclk
    assign wr_ptr_next = wr_ptr + 1'b1;
    assign rd_pair_wr  = gray_to_bin({1'b0, rd_gray_s1});
    assign wr_used     = wr_ptr - {rd_pair_wr[PAIR_PTR_W-1:0], 1'b0};
    assign fifo_full   = wr_used[PIXEL_ADDR_W];               // set only at exactly full
    assign wr_accept   = wr_en & ~fifo_full;                  // full writes are dropped

    always_ff @(posedge pclk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr  <= '0;
            wr_gray <= '0;
        end
        else if (wr_clear)
        begin
            wr_ptr  <= '0;
            wr_gray <= '0;
        end
        else if (wr_accept)
        begin
            wr_ptr  <= wr_ptr_next;
            wr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
        end
    end

    always_ff @(posedge pclk)
    begin
        if (wr_accept)
        begin
            mem[wr_ptr[PIXEL_ADDR_W-1:1]][wr_ptr[0]] <= wr_data;
        end
    end

    always_ff @(posedge pclk or posedge rst)
    begin
        if (rst)
        begin
            rd_gray_s0 <= '0;
            rd_gray_s1 <= '0;
        end
        else
        begin
            rd_gray_s0 <= rd_gray;
            rd_gray_s1 <= rd_gray_s0;
        end
    end

    // read side, tx_clk
    assign rd_ptr_next = rd_ptr + 1'b1;
    assign rd_addr     = rd_ptr[PAIR_PTR_W-2:0];

    always_ff @(posedge tx_clk or posedge rst)
    begin
        if (rst)
        begin
            rd_ptr  <= '0;
            rd_gray <= '0;
        end
        else if (rd_clear)
        begin
            rd_ptr  <= '0;
            rd_gray <= '0;
        end
        else if (rd_en)
        begin
            rd_ptr  <= rd_ptr_next;                           // two pixels per read
            rd_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
        end
    end

    always_ff @(posedge tx_clk or posedge rst)
    begin
        if (rst)
        begin
            wr_gray_s0 <= '0;
            wr_gray_s1 <= '0;
        end
        else
        begin
            wr_gray_s0 <= wr_gray;
            wr_gray_s1 <= wr_gray_s0;
        end
    end

    assign wr_ptr_rd  = gray_to_bin(wr_gray_s1);
    assign fifo_level = wr_ptr_rd - {rd_ptr, 1'b0};           // lags writes, never overstates
    assign rd_data    = {mem[rd_addr][1], mem[rd_addr][0]};   // head word, fall-through

endmodule

// File: design/vs_frame_sync.sv
`timescale 1ns/10ps

module vs_frame_sync (
    input  logic tx_clk,
    input  logic pclk,
    input  logic rst,
    input  logic vs,
    output logic frame_start_pclk,
    output logic frame_start_tx
);

    logic [1:0] dom_clk;                                      // bit 0 tx_clk, bit 1 pclk
    logic [1:0] frame_start;

    assign dom_clk = {pclk, tx_clk};

    // same chain in both domains, only the clock differs
    for (genvar d = 0; d < 2; d++)
    begin : g_domain
        logic [2:0] vs_sync;                                  // [0] meta, [1] stable, [2] history
        logic       start_pulse;

        always_ff @(posedge dom_clk[d] or posedge rst)
        begin
            if (rst)
            begin
                vs_sync     <= '0;
                start_pulse <= 1'b0;
            end
            else
            begin
                vs_sync     <= {vs_sync[1:0], vs};
                start_pulse <= vs_sync[1] & ~vs_sync[2];      // rising edge of vs
            end
        end

        assign frame_start[d] = start_pulse;
    end

    assign frame_start_tx   = frame_start[0];
    assign frame_start_pclk = frame_start[1];

endmodule

// File: design/video_link_pkg.sv
package video_link_pkg;

    localparam int PIXEL_FIFO_DEPTH = 4096;                   // buffer capacity in pixels
    localparam int PIXEL_ADDR_W     = $clog2(PIXEL_FIFO_DEPTH);

    typedef logic [15:0]           pixel_t;                   // one camera pixel
    typedef logic [31:0]           link_word_t;               // transceiver data word
    typedef logic [3:0]            link_ctrl_t;               // k-char flag per byte
    typedef logic [15:0]           line_len_t;                // line width in pixels
    typedef logic [PIXEL_ADDR_W:0] fifo_level_t;              // room for a full buffer

    // every control word carries a K28.5 comma in byte 0
    localparam link_word_t FRAME_SYNC0_WORD = 32'hff00_00bc;
    localparam link_word_t FRAME_SYNC1_WORD = 32'hff00_01bc;
    localparam link_word_t IDLE0_WORD       = 32'hff55_55bc;
    localparam link_word_t IDLE1_WORD       = 32'hffaa_aabc;
    localparam link_word_t LINE_START_WORD  = 32'hff00_02bc;
    localparam link_word_t LINE_END_WORD    = 32'hff00_03bc;

    localparam link_ctrl_t CTRL_K0   = 4'b0001;               // comma in byte 0 only
    localparam link_ctrl_t CTRL_DATA = 4'b0000;               // plain pixel data

    typedef enum logic [2:0] {
        SEND_FRAME_SYNC0,
        SEND_FRAME_SYNC1,
        SEND_IDLE0,
        SEND_IDLE1,
        SEND_LINE_START,
        SEND_LINE_DATA,
        SEND_LINE_END
    } framer_state_e;

endpackage
